// ==== Makefile ====
TOP := tb_besm_mmu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f build.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+include
hdl/besm_pkg.sv
hdl/access_ctrl.sv
hdl/page_table.sv
hdl/reprio_store.sv
hdl/ext_bus_seq.sv
hdl/besm_mmu_top.sv
tests/tb_ext_mem.sv
tests/tb_besm_mmu.sv

// ==== hdl/access_ctrl.sv ====
// Host command FSM: decodes commands, checks page protection, starts memory cycles
`timescale 1ns/1ns
`include "besm_params.svh"

module access_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_cyc,
    input  logic                 i_stb,
    input  besm_pkg::host_cmd_t  i_cmd,
    output logic                 o_ack,
    output besm_pkg::host_rsp_t  o_rsp,
    output besm_pkg::page_idx_t  o_pg_index,
    output logic                 o_map_we,
    output logic                 o_acc_we,
    output besm_pkg::ppage_t     o_pg_wdata,
    input  besm_pkg::ppage_t     i_ppage,
    input  logic                 i_pg_inv,
    input  logic                 i_pg_ro,
    output logic                 o_reprio_we,
    output logic                 o_reprio_bit,
    input  logic                 i_reprio_bit,
    output logic                 o_fill_start,
    input  logic                 i_fill_busy,
    output logic                 o_seq_req,
    output besm_pkg::mem_req_t   o_seq_cmd,
    input  logic                 i_seq_done,
    input  besm_pkg::word_t      i_seq_rdata
);

    besm_pkg::ctrl_state_e state, state_d;
    besm_pkg::host_cmd_t   cmd_q;                // Command latched at first stb
    besm_pkg::host_rsp_t   rsp_q;
    besm_pkg::host_op_e    op;
    besm_pkg::fault_e      fault_d;
    logic [`BESM_OFFSET_W-1:0] offset;
    besm_pkg::word_t       bit_word;
    logic is_mem, is_reprio, reprio_go, reprio_rd;

    assign op         = cmd_q.op;
    assign o_pg_index = cmd_q.vaddr[`BESM_VADDR_W-1 -: `BESM_PAGE_W]; // Upper bits
    assign offset     = cmd_q.vaddr[`BESM_OFFSET_W-1:0];
    assign o_pg_wdata = cmd_q.wdata[`BESM_PPAGE_W-1:0];
    assign bit_word   = {{(`BESM_DATA_W-1){1'b0}}, i_reprio_bit};

    assign is_mem    = (op == besm_pkg::OP_LOAD) || (op == besm_pkg::OP_STORE);
    assign is_reprio = (op == besm_pkg::OP_REPRIO_WRITE) || (op == besm_pkg::OP_REPRIO_READ)
                    || (op == besm_pkg::OP_FILL_START);
    // Reprio commands proceed only with the sweep idle
    assign reprio_go = is_reprio && !i_fill_busy
                    && (state == besm_pkg::LOOKUP || state == besm_pkg::FILL_WAIT);
    assign reprio_rd = reprio_go && (op == besm_pkg::OP_REPRIO_READ);

    // Invalid wins over read-only
    always_comb begin
        if (i_pg_inv)
            fault_d = besm_pkg::FAULT_INVALID;
        else if (i_pg_ro && op == besm_pkg::OP_STORE)
            fault_d = besm_pkg::FAULT_READONLY;
        else
            fault_d = besm_pkg::FAULT_NONE;
    end

    // ------------------------------
    // Side effects of the command
    // ------------------------------
    assign o_map_we     = (state == besm_pkg::LOOKUP) && (op == besm_pkg::OP_MAP_WRITE);
    assign o_acc_we     = (state == besm_pkg::LOOKUP) && (op == besm_pkg::OP_ACC_WRITE);
    assign o_reprio_we  = reprio_go && (op == besm_pkg::OP_REPRIO_WRITE);
    assign o_reprio_bit = cmd_q.wdata[0];
    assign o_fill_start = reprio_go && (op == besm_pkg::OP_FILL_START);
    assign o_seq_req    = (state == besm_pkg::LOOKUP) && is_mem
                       && (fault_d == besm_pkg::FAULT_NONE);   // Faults skip the bus

    always_comb begin
        o_seq_cmd.adr = {i_ppage, offset};        // Mapped page joined with offset
        o_seq_cmd.dat = cmd_q.wdata;
        o_seq_cmd.we  = (op == besm_pkg::OP_STORE);
    end

    assign o_ack = (state == besm_pkg::RESPOND); // One cycle, RESPOND never repeats
    assign o_rsp = rsp_q;

    // ------------------------------
    // Control FSM
    // ------------------------------
    always_comb begin
        state_d = state;
        case (state)
            besm_pkg::IDLE:      if (i_cyc && i_stb) state_d = besm_pkg::LOOKUP;
            besm_pkg::LOOKUP: begin
                if (is_reprio && i_fill_busy)
                    state_d = besm_pkg::FILL_WAIT;   // Sweep still running
                else if (o_seq_req)
                    state_d = besm_pkg::BUS_WAIT;
                else
                    state_d = besm_pkg::RESPOND;
            end
            besm_pkg::FILL_WAIT: if (!i_fill_busy) state_d = besm_pkg::RESPOND;
            besm_pkg::BUS_WAIT:  if (i_seq_done) state_d = besm_pkg::RESPOND;
            default:             state_d = besm_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= besm_pkg::IDLE;
        else
            state <= state_d;
    end

    always_ff @(posedge clk) begin
        if (state == besm_pkg::IDLE && i_cyc && i_stb)
            cmd_q <= i_cmd;
        if (state == besm_pkg::LOOKUP) begin
            rsp_q.rdata <= reprio_rd ? bit_word : '0;
            rsp_q.fault <= is_mem ? fault_d : besm_pkg::FAULT_NONE;
        end else if (state == besm_pkg::FILL_WAIT && reprio_rd) begin
            rsp_q.rdata <= bit_word;
        end else if (state == besm_pkg::BUS_WAIT && i_seq_done) begin
            rsp_q.rdata <= (op == besm_pkg::OP_STORE) ? '0 : i_seq_rdata; // Stores read zero
        end
    end

    // Host sees a single-cycle ack per command
    ack_single : assert property (@(posedge clk) disable iff (reset) o_ack |=> !o_ack);

endmodule

// ==== hdl/besm_mmu_top.sv ====
// Paging unit top: host command port, page table, reprioritize bits, external bus
`timescale 1ns/1ns

module besm_mmu_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_cyc,          // Host Wishbone cycle
    input  logic                 i_stb,
    input  besm_pkg::host_cmd_t  i_cmd,
    output logic                 o_ack,
    output besm_pkg::host_rsp_t  o_rsp,
    output logic                 o_mem_cyc,      // Memory Wishbone master
    output logic                 o_mem_stb,
    output besm_pkg::mem_req_t   o_mem,
    input  logic                 i_mem_ack,
    input  besm_pkg::word_t      i_mem_dat
);

    besm_pkg::page_idx_t pg_index;               // Shared lookup and write index
    besm_pkg::ppage_t    pg_wdata;
    besm_pkg::ppage_t    ppage;
    logic                map_we, acc_we;
    logic                pg_inv, pg_ro;
    logic                reprio_we, reprio_wbit, reprio_rbit;
    logic                fill_start, fill_busy;
    logic                seq_req, seq_done;
    besm_pkg::mem_req_t  seq_cmd;
    besm_pkg::word_t     seq_rdata;

    access_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .i_cyc(i_cyc), .i_stb(i_stb), .i_cmd(i_cmd), .o_ack(o_ack), .o_rsp(o_rsp),
        .o_pg_index(pg_index), .o_map_we(map_we), .o_acc_we(acc_we), .o_pg_wdata(pg_wdata),
        .i_ppage(ppage), .i_pg_inv(pg_inv), .i_pg_ro(pg_ro),
        .o_reprio_we(reprio_we), .o_reprio_bit(reprio_wbit), .i_reprio_bit(reprio_rbit),
        .o_fill_start(fill_start), .i_fill_busy(fill_busy),
        .o_seq_req(seq_req), .o_seq_cmd(seq_cmd), .i_seq_done(seq_done),
        .i_seq_rdata(seq_rdata)
    );

    page_table u_pages (
        .clk(clk), .i_index(pg_index), .i_map_we(map_we), .i_acc_we(acc_we),
        .i_wdata(pg_wdata), .o_ppage(ppage), .o_inv(pg_inv), .o_ro(pg_ro)
    );

    reprio_store u_reprio (
        .clk(clk), .reset(reset), .i_index(pg_index), .i_we(reprio_we),
        .i_bit(reprio_wbit), .i_fill_start(fill_start), .o_bit(reprio_rbit), .o_busy(fill_busy)
    );

    ext_bus_seq u_seq (
        .clk(clk), .reset(reset), .i_req(seq_req), .i_cmd(seq_cmd), .o_done(seq_done),
        .o_rdata(seq_rdata), .o_mem_cyc(o_mem_cyc), .o_mem_stb(o_mem_stb), .o_mem(o_mem),
        .i_mem_ack(i_mem_ack), .i_mem_dat(i_mem_dat)
    );

endmodule

// ==== hdl/besm_pkg.sv ====
// Shared types of the paging unit: host command and response, memory request, FSM states
`include "besm_params.svh"

package besm_pkg;

    typedef logic [`BESM_PAGE_W-1:0]  page_idx_t;    // Virtual page index
    typedef logic [`BESM_PPAGE_W-1:0] ppage_t;       // Physical page number
    typedef logic [`BESM_VADDR_W-1:0] vaddr_t;
    typedef logic [`BESM_PADDR_W-1:0] paddr_t;
    typedef logic [`BESM_DATA_W-1:0]  word_t;        // Machine word

    // ------------------------------
    // Host command opcodes
    // ------------------------------
    typedef enum logic [2:0] {
        OP_MAP_WRITE,                                // Page map entry
        OP_ACC_WRITE,                                // Invalid and read-only bits
        OP_REPRIO_WRITE,
        OP_REPRIO_READ,
        OP_FILL_START,                               // Sweep ones to the last page
        OP_LOAD,
        OP_STORE
    } host_op_e;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_INVALID,                               // Page access blocked
        FAULT_READONLY                               // Store to protected page
    } fault_e;

    typedef struct packed {
        host_op_e op;
        vaddr_t   vaddr;
        word_t    wdata;
    } host_cmd_t;

    typedef struct packed {
        word_t  rdata;
        fault_e fault;
    } host_rsp_t;

    typedef struct packed {
        paddr_t adr;
        word_t  dat;
        logic   we;                                  // Store cycle
    } mem_req_t;

    typedef enum logic [2:0] {IDLE, LOOKUP, BUS_WAIT, FILL_WAIT, RESPOND} ctrl_state_e;
    typedef enum logic {SEQ_IDLE, SEQ_CYCLE} seq_state_e;

endpackage

// ==== hdl/ext_bus_seq.sv ====
// Wishbone classic master sequencer for single external memory cycles
`timescale 1ns/1ns
`include "besm_params.svh"

module ext_bus_seq (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_req,           // One-cycle request pulse
    input  besm_pkg::mem_req_t  i_cmd,
    output logic                o_done,          // One cycle after ack
    output besm_pkg::word_t     o_rdata,
    output logic                o_mem_cyc,
    output logic                o_mem_stb,
    output besm_pkg::mem_req_t  o_mem,
    input  logic                i_mem_ack,
    input  besm_pkg::word_t     i_mem_dat
);

    besm_pkg::seq_state_e state;

    // ------------------------------
    // Cycle control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= besm_pkg::SEQ_IDLE;
            o_mem_cyc <= 1'b0;
            o_mem_stb <= 1'b0;
            o_done    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                besm_pkg::SEQ_IDLE: begin
                    if (i_req) begin
                        state     <= besm_pkg::SEQ_CYCLE;
                        o_mem_cyc <= 1'b1;       // Cyc and stb rise together
                        o_mem_stb <= 1'b1;
                    end
                end
                default: begin
                    if (i_mem_ack) begin
                        state     <= besm_pkg::SEQ_IDLE;
                        o_mem_cyc <= 1'b0;
                        o_mem_stb <= 1'b0;
                        o_done    <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Request held on the bus, read data caught on ack
    always_ff @(posedge clk) begin
        if (state == besm_pkg::SEQ_IDLE && i_req)
            o_mem <= i_cmd;
        if (state == besm_pkg::SEQ_CYCLE && i_mem_ack)
            o_rdata <= i_mem_dat;
    end

    stb_in_cyc : assert property (@(posedge clk) disable iff (reset)
        o_mem_stb |-> o_mem_cyc);

endmodule

// ==== hdl/page_table.sv ====
// Page map with invalid and read-only bits, one write port and one combinational lookup
`timescale 1ns/1ns
`include "besm_params.svh"

module page_table (
    input  logic                 clk,
    input  besm_pkg::page_idx_t  i_index,        // Shared write and lookup index
    input  logic                 i_map_we,
    input  logic                 i_acc_we,
    input  besm_pkg::ppage_t     i_wdata,
    output besm_pkg::ppage_t     o_ppage,
    output logic                 o_inv,
    output logic                 o_ro
);

    // ------------------------------
    // Storage
    // ------------------------------
    besm_pkg::ppage_t map_mem [`BESM_PAGES];     // Physical page per virtual page
    logic             inv_mem [`BESM_PAGES];     // Access blocked
    logic             ro_mem  [`BESM_PAGES];     // Store blocked

    always_ff @(posedge clk) begin
        if (i_map_we)
            map_mem[i_index] <= i_wdata;
        if (i_acc_we) begin
            inv_mem[i_index] <= i_wdata[1];      // Bit 1 invalid
            ro_mem[i_index]  <= i_wdata[2];      // Bit 2 read-only
        end
    end

    // Same-cycle lookup for the protection check
    assign o_ppage = map_mem[i_index];
    assign o_inv   = inv_mem[i_index];
    assign o_ro    = ro_mem[i_index];

endmodule

// ==== hdl/reprio_store.sv ====
// Reprioritize bit memory with a sweep that fills ones from a start page to the last page
`timescale 1ns/1ns
`include "besm_params.svh"

module reprio_store (
    input  logic                 clk,
    input  logic                 reset,
    input  besm_pkg::page_idx_t  i_index,
    input  logic                 i_we,
    input  logic                 i_bit,
    input  logic                 i_fill_start,   // Sweep from i_index
    output logic                 o_bit,
    output logic                 o_busy
);

    logic                reprio_mem [`BESM_PAGES];
    besm_pkg::page_idx_t fill_cnt;               // Page written this cycle
    logic                fill_last;

    assign fill_last = (fill_cnt == `BESM_PAGE_W'(`BESM_PAGES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            o_busy   <= 1'b0;
            fill_cnt <= '0;
        end else if (i_fill_start) begin
            o_busy   <= 1'b1;
            fill_cnt <= i_index;
        end else if (o_busy) begin
            if (fill_last)
                o_busy <= 1'b0;                  // Last page reached
            else
                fill_cnt <= fill_cnt + 1'b1;
        end
    end

    // Sweep owns the write port while busy
    always_ff @(posedge clk) begin
        if (o_busy)
            reprio_mem[fill_cnt] <= 1'b1;
        else if (i_we)
            reprio_mem[i_index] <= i_bit;
    end

    assign o_bit = reprio_mem[i_index];

    // Controller must hold new sweeps until the current one ends
    fill_no_restart : assert property (@(posedge clk) disable iff (reset)
        i_fill_start |-> !o_busy);

endmodule

// ==== include/besm_params.svh ====
// Paging unit sizes: page index, word offset, address and data widths
`ifndef BESM_PARAMS_SVH
`define BESM_PARAMS_SVH

// ------------------------------
// Virtual side
// ------------------------------
`define BESM_PAGE_W    10                            // Virtual page index
`define BESM_PAGES     1024                          // Pages in the map
`define BESM_OFFSET_W  10                            // Word offset in a page
`define BESM_VADDR_W   (`BESM_PAGE_W + `BESM_OFFSET_W)

// ------------------------------
// Physical side
// ------------------------------
`define BESM_PPAGE_W   10                            // Physical page number
`define BESM_PADDR_W   (`BESM_PPAGE_W + `BESM_OFFSET_W)
`define BESM_DATA_W    64                            // Machine word

`endif

// ==== tests/tb_besm_mmu.sv ====
// Paging unit testbench: command table through the host port, response checks, verdict
`timescale 1ns/1ns
`include "besm_params.svh"

module tb_besm_mmu;

    typedef struct packed {
        besm_pkg::host_op_e op;
        besm_pkg::vaddr_t   vaddr;
        besm_pkg::word_t    wdata;
        besm_pkg::word_t    exp_rdata;
        besm_pkg::fault_e   exp_fault;
    } step_t;

    localparam besm_pkg::word_t WORD_A = 64'h0123_4567_89ab_cdef;
    localparam besm_pkg::word_t WORD_B = 64'hfedc_ba98_7654_3210;
    localparam besm_pkg::word_t WORD_C = 64'h5555_aaaa_5555_aaaa;
    localparam besm_pkg::word_t WORD_D = 64'h0bad_cafe_dead_beef;
    localparam besm_pkg::word_t WORD_E = 64'h1111_2222_3333_4444;

    logic clk, reset, cyc, stb, ack, mem_cyc, mem_stb, mem_ack;
    besm_pkg::host_cmd_t cmd;
    besm_pkg::host_rsp_t rsp;
    besm_pkg::mem_req_t  mem;
    besm_pkg::word_t     mem_dat;
    step_t               steps [$];
    logic                table_ready;
    int                  errors, failed_steps;

    besm_mmu_top i_dut (
        .clk(clk), .reset(reset), .i_cyc(cyc), .i_stb(stb), .i_cmd(cmd), .o_ack(ack),
        .o_rsp(rsp), .o_mem_cyc(mem_cyc), .o_mem_stb(mem_stb), .o_mem(mem),
        .i_mem_ack(mem_ack), .i_mem_dat(mem_dat)
    );

    tb_ext_mem u_mem (
        .clk(clk), .reset(reset), .i_cyc(mem_cyc), .i_stb(mem_stb), .i_mem(mem),
        .o_ack(mem_ack), .o_dat(mem_dat)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                   // 4 ns period
    end

    task automatic add_step(input besm_pkg::host_op_e op, input int page, input int offset,
                            input besm_pkg::word_t wdata, input besm_pkg::word_t exp_rdata,
                            input besm_pkg::fault_e exp_fault);
        besm_pkg::vaddr_t vaddr;
        vaddr = {page[`BESM_PAGE_W-1:0], offset[`BESM_OFFSET_W-1:0]};
        steps.push_back('{op, vaddr, wdata, exp_rdata, exp_fault});
    endtask

    // ------------------------------
    // One host transaction
    // ------------------------------
    task automatic run_step(input int n, input step_t s);
        besm_pkg::host_op_e op;
        int cycles;
        int fails;
        op     = s.op;
        cycles = 0;
        fails  = 0;
        cmd.op    = s.op;
        cmd.vaddr = s.vaddr;
        cmd.wdata = s.wdata;
        cyc = 1'b1;
        stb = 1'b1;
        @(posedge clk);                          // Edge that samples stb
        do begin
            @(negedge clk);                      // Ack and response settled
            cycles++;
        end while (!ack);
        if (rsp.rdata !== s.exp_rdata) begin
            $display("error at %0t ns: step %0d %s rdata %h, expected %h",
                     $time, n, op.name(), rsp.rdata, s.exp_rdata);
            fails++;
        end
        if (rsp.fault !== s.exp_fault) begin
            $display("error at %0t ns: step %0d %s fault %0d, expected %0d",
                     $time, n, op.name(), rsp.fault, s.exp_fault);
            fails++;
        end
        @(posedge clk);
        #1;
        cyc = 1'b0;                              // Drop stb after the ack cycle
        stb = 1'b0;
        errors += fails;
        if (fails != 0)
            failed_steps++;
        $display("step %0d %s %s, ack after %0d cycles", n, op.name(),
                 (fails == 0) ? "ok" : "failed", cycles);
        @(posedge clk);                          // One idle cycle with stb low
        #1;
    endtask

    initial begin
        reset        = 1'b1;
        cyc          = 1'b0;
        stb          = 1'b0;
        cmd          = '0;
        errors       = 0;
        failed_steps = 0;
        table_ready  = 1'b0;
        // Mapped write and read, page 3 on physical page 7
        add_step(besm_pkg::OP_MAP_WRITE, 3, 0, 64'd7, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_ACC_WRITE, 3, 0, 64'd0, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_STORE, 3, 'h15, WORD_A, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_LOAD, 3, 'h15, '0, WORD_A, besm_pkg::FAULT_NONE);
        // Alias page 40 on the same physical page
        add_step(besm_pkg::OP_MAP_WRITE, 40, 0, 64'd7, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_ACC_WRITE, 40, 0, 64'd0, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_LOAD, 40, 'h15, '0, WORD_A, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_STORE, 40, 'h22, WORD_B, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_LOAD, 3, 'h22, '0, WORD_B, besm_pkg::FAULT_NONE);
        // Invalid page 50, also aliased on page 7
        add_step(besm_pkg::OP_MAP_WRITE, 50, 0, 64'd7, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_ACC_WRITE, 50, 0, 64'd2, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_LOAD, 50, 'h15, '0, '0, besm_pkg::FAULT_INVALID);
        add_step(besm_pkg::OP_STORE, 50, 'h15, WORD_C, '0, besm_pkg::FAULT_INVALID);
        add_step(besm_pkg::OP_ACC_WRITE, 50, 0, 64'd6, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_STORE, 50, 'h15, WORD_C, '0, besm_pkg::FAULT_INVALID); // Invalid wins
        add_step(besm_pkg::OP_LOAD, 3, 'h15, '0, WORD_A, besm_pkg::FAULT_NONE);
        // Read-only page 60 with writable alias 61 on physical page 9
        add_step(besm_pkg::OP_MAP_WRITE, 60, 0, 64'd9, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_ACC_WRITE, 60, 0, 64'd4, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_MAP_WRITE, 61, 0, 64'd9, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_ACC_WRITE, 61, 0, 64'd0, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_STORE, 61, 'h30, WORD_D, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_STORE, 60, 'h30, WORD_E, '0, besm_pkg::FAULT_READONLY);
        add_step(besm_pkg::OP_LOAD, 60, 'h30, '0, WORD_D, besm_pkg::FAULT_NONE);
        // Reprioritize bits and the sweep from page 600
        add_step(besm_pkg::OP_REPRIO_WRITE, 5, 0, 64'd1, '0, besm_pkg::FAULT_NONE); // Set first
        add_step(besm_pkg::OP_REPRIO_READ, 5, 0, '0, 64'd1, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_REPRIO_WRITE, 5, 0, 64'd0, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_REPRIO_WRITE, 900, 0, 64'd0, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_REPRIO_READ, 5, 0, '0, 64'd0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_REPRIO_READ, 900, 0, '0, 64'd0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_FILL_START, 600, 0, '0, '0, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_REPRIO_READ, 900, 0, '0, 64'd1, besm_pkg::FAULT_NONE);
        add_step(besm_pkg::OP_REPRIO_READ, 5, 0, '0, 64'd0, besm_pkg::FAULT_NONE);
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (steps[i])
            run_step(i, steps[i]);
        $display("%0d steps, %0d passed, %0d failed, %0d errors", steps.size(),
                 steps.size() - failed_steps, failed_steps, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // ------------------------------
    // Watchdog
    // ------------------------------
    initial begin
        wait (table_ready);
        repeat (steps.size() * 16 + 1024 + 5) @(posedge clk);   // 16 per step plus sweep
        $display("Watchdog expired: the DUT stopped acknowledging host commands");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== tests/tb_ext_mem.sv ====
// External memory model: Wishbone classic slave with random wait states
`timescale 1ns/1ns

module tb_ext_mem (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_cyc,
    input  logic               i_stb,
    input  besm_pkg::mem_req_t i_mem,
    output logic               o_ack,
    output besm_pkg::word_t    o_dat
);

    besm_pkg::word_t words [4096];               // Indexed by low 12 address bits
    logic [31:0]     lcg;                        // Wait state generator
    logic [1:0]      wait_cnt;
    logic            pending;                    // Cycle seen, waits counting down

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        o_ack = 1'b0;                            // Quiet bus before the first edge
        o_dat = '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            o_ack    <= 1'b0;
            pending  <= 1'b0;
            wait_cnt <= 2'd0;
            lcg      <= 32'd42886;
        end else begin
            o_ack <= 1'b0;
            if (i_cyc && i_stb && !o_ack && !pending) begin
                pending  <= 1'b1;
                wait_cnt <= lcg[17:16];          // 0 to 3 wait states
                lcg      <= lcg_next(lcg);
            end else if (pending && wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else if (pending) begin
                pending <= 1'b0;
                o_ack   <= 1'b1;                 // Single-cycle ack
                o_dat   <= words[i_mem.adr[11:0]];
                if (i_mem.we)
                    words[i_mem.adr[11:0]] <= i_mem.dat;
            end
        end
    end

endmodule
